//--- Bender.yml
package:
  name: rv_soc

sources:
  - rtl/rv_pkg.sv
  - rtl/mem_bus_if.sv
  - rtl/rv_decode.sv
  - rtl/rv_core.sv
  - rtl/rv_mem.sv
  - rtl/rv_soc.sv
  - target: simulation
    files:
      - bench/rv_soc_tb.sv

//--- bench/rv_soc_tb.sv
// Run from the project root; reads bench/rv_soc_testdata.txt and gives each section its own reset and reload
`timescale 1ns/1ps

module rv_soc_tb;
    import rv_pkg::*;

    // Cycles that halt must hold before a section is closed
    localparam int HOLD_CYCLES = 16;

    logic              clk;
    logic              rst;
    logic              load_en;
    logic [MEM_AW-1:0] load_addr;
    logic [XLEN-1:0]   load_data;
    logic              out_valid;
    logic [XLEN-1:0]   out_data;
    logic              halt;

    logic [MEM_AW-1:0] prog_addr [$];
    logic [XLEN-1:0]   prog_word [$];
    logic [XLEN-1:0]   exp_q [$];
    logic [XLEN-1:0]   exp_word;
    logic              halt_exp;
    string             wait_what;
    int                fd;
    int                allowance;
    int                cycle_limit;
    int                cycles;
    int                section;
    int                mismatches;
    int                other_errors;

    rv_soc u_dut (
        .clk       (clk),
        .rst       (rst),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .out_valid (out_valid),
        .out_data  (out_data),
        .halt      (halt)
    );

    always #4 clk = ~clk;

    task automatic finish_run();
        $display("Checks done: %0d mismatches, %0d other errors", mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    endtask

    task automatic check_idle(input string phase);
        if (out_valid !== 1'b0) begin
            $display("Mismatch: out_valid %s expected 0 got %h", phase, out_valid);
            mismatches++;
        end
        if (halt !== 1'b0) begin
            $display("Mismatch: halt %s expected 0 got %h", phase, halt);
            mismatches++;
        end
    endtask

    // A section is every P and E line up to and including its H line
    task automatic read_section(output bit found);
        byte                ch;
        logic [XLEN-1:0]    a;
        logic [XLEN-1:0]    w;
        string              line;
        int                 n;
        int                 rc;
        found = 1'b0;
        prog_addr.delete();
        prog_word.delete();
        exp_q.delete();
        halt_exp = 1'b0;
        while (!found && !$feof(fd)) begin
            rc = $fscanf(fd, " %c", ch);
            if (rc == 1) begin
                case (ch)
                    "#": begin
                        rc = $fgets(line, fd);
                        if ($sscanf(line, " loop allowance %d", n) == 1) begin
                            allowance = n;
                        end
                    end
                    "P": begin
                        rc = $fscanf(fd, "%h %h", a, w);
                        prog_addr.push_back(a[MEM_AW-1:0]);
                        prog_word.push_back(w);
                    end
                    "E": begin
                        rc = $fscanf(fd, "%h", w);
                        exp_q.push_back(w);
                    end
                    "H": begin
                        rc = $fscanf(fd, "%h", w);
                        halt_exp = w[0];
                        found = 1'b1;
                    end
                    default: begin
                        $display("Unknown line tag '%c' in the test data", ch);
                        other_errors++;
                        rc = $fgets(line, fd);
                    end
                endcase
            end
        end
    endtask

    task automatic run_section();
        rst = 1'b1;
        cycle_limit = prog_word.size() * 8 * allowance;
        // Program goes in while reset is held and 8 more reset cycles follow
        for (int i = 0; i < prog_word.size(); i++) begin
            @(negedge clk);
            load_en   = 1'b1;
            load_addr = prog_addr[i];
            load_data = prog_word[i];
        end
        @(negedge clk);
        load_en = 1'b0;
        repeat (8) @(negedge clk);
        check_idle("during reset");
        rst = 1'b0;
        @(negedge clk);
        check_idle("right after reset");
        if (halt_exp) begin
            wait_what = "halt to rise";
            while (!halt) @(negedge clk);
            wait_what = "the halt hold check";
            repeat (HOLD_CYCLES) begin
                @(negedge clk);
                if (!halt) begin
                    $display("halt fell again in section %0d before any reset", section);
                    other_errors++;
                end
            end
        end else begin
            wait_what = "the expected output words";
            while (exp_q.size() != 0) @(negedge clk);
            repeat (HOLD_CYCLES) @(negedge clk);
            if (halt) begin
                $display("halt rose in section %0d although none was expected", section);
                other_errors++;
            end
        end
        if (exp_q.size() != 0) begin
            $display("%0d expected output words never appeared in section %0d",
                     exp_q.size(), section);
            other_errors++;
        end
    endtask

    // Compare each output strobe against the next expected word
    always @(posedge clk) begin
        if (!rst && out_valid) begin
            if (halt) begin
                $display("out_valid strobed while halt was already high");
                other_errors++;
            end
            if (exp_q.size() == 0) begin
                $display("Extra output word %08h with no expected word left", out_data);
                other_errors++;
            end else begin
                exp_word = exp_q.pop_front();
                if (out_data !== exp_word) begin
                    $display("Mismatch: out_data expected %08h got %08h", exp_word, out_data);
                    mismatches++;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (rst) begin
            cycles = 0;
        end else begin
            cycles = cycles + 1;
            if (cycles > cycle_limit) begin
                $display("Timeout: section %0d still waiting for %s after %0d cycles",
                         section, wait_what, cycle_limit);
                other_errors++;
                finish_run();
            end
        end
    end

    initial begin
        bit found;
        clk = 1'b0;
        rst = 1'b1;
        load_en = 1'b0;
        load_addr = '0;
        load_data = '0;
        mismatches = 0;
        other_errors = 0;
        allowance = 1;
        cycle_limit = 0;
        section = 0;
        wait_what = "reset";
        fd = $fopen("bench/rv_soc_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open bench/rv_soc_testdata.txt");
            other_errors++;
        end else begin
            found = 1'b1;
            while (found) begin
                read_section(found);
                if (found) begin
                    section++;
                    run_section();
                end
            end
            $fclose(fd);
            if (section == 0) begin
                $display("The test data holds no complete program section");
                other_errors++;
            end
        end
        finish_run();
    end

endmodule

//--- bench/rv_soc_testdata.txt
# Columns: P <word addr> <word> | E <expected out_data> | H <halt expected>, hex
# Each H line closes a section; timeout is words x 8 x loop allowance
# loop allowance 4
P 000 00500093 # addi x1, x0, 5
P 001 3E102423 # sw x1, 1000(x0)
P 002 FFD00113 # addi x2, x0, -3
P 003 3E202423 # sw x2, 1000(x0)
P 004 80010193 # addi x3, x2, -2048
P 005 3E302423 # sw x3, 1000(x0)
P 006 06408013 # addi x0, x1, 100
P 007 3E002423 # sw x0, 1000(x0)
P 008 7FF08213 # addi x4, x1, 2047
P 009 3E402423 # sw x4, 1000(x0)
P 00A 20302023 # sw x3, 512(x0)
P 00B 20002283 # lw x5, 512(x0)
P 00C 3E502423 # sw x5, 1000(x0)
P 00D 30002303 # lw x6, 768(x0)
P 00E 3E602423 # sw x6, 1000(x0)
P 00F FFF00393 # addi x7, x0, -1
P 010 00108463 # beq x1, x1, +8 taken
P 011 3E002423 # sw x0, 1000(x0)
P 012 00138463 # beq x7, x1, +8 not taken
P 013 3E102423 # sw x1, 1000(x0)
P 014 00139463 # bne x7, x1, +8 taken
P 015 3E002423 # sw x0, 1000(x0)
P 016 00109463 # bne x1, x1, +8 not taken
P 017 3E202423 # sw x2, 1000(x0)
P 018 0013C463 # blt x7, x1, +8 taken, -1 < 5
P 019 3E002423 # sw x0, 1000(x0)
P 01A 0070C463 # blt x1, x7, +8 not taken
P 01B 3E402423 # sw x4, 1000(x0)
P 01C 0070D463 # bge x1, x7, +8 taken
P 01D 3E002423 # sw x0, 1000(x0)
P 01E 0013D463 # bge x7, x1, +8 not taken
P 01F 3E602423 # sw x6, 1000(x0)
P 020 0070E463 # bltu x1, x7, +8 taken, 5 < ffffffff
P 021 3E002423 # sw x0, 1000(x0)
P 022 0013E463 # bltu x7, x1, +8 not taken
P 023 3E302423 # sw x3, 1000(x0)
P 024 0013F463 # bgeu x7, x1, +8 taken
P 025 3E002423 # sw x0, 1000(x0)
P 026 0070F463 # bgeu x1, x7, +8 not taken
P 027 3E702423 # sw x7, 1000(x0)
P 028 00300413 # addi x8, x0, 3
P 029 3E802423 # loop: sw x8, 1000(x0)
P 02A FFF40413 # addi x8, x8, -1
P 02B FE041CE3 # bne x8, x0, loop
P 02C 3E002623 # sw x0, 1004(x0) halts
P 02D 3E102423 # sw x1, 1000(x0) never runs
P 0C0 CAFE1234 # preset data word at byte 768
E 00000005
E FFFFFFFD
E FFFFF7FD
E 00000000
E 00000804
E FFFFF7FD
E CAFE1234
E 00000005
E FFFFFFFD
E 00000804
E CAFE1234
E FFFFF7FD
E FFFFFFFF
E 00000003
E 00000002
E 00000001
H 1
# Second section ends on an unknown opcode
P 000 00700093 # addi x1, x0, 7
P 001 3E102423 # sw x1, 1000(x0)
P 002 0000000B # custom-0 opcode halts
P 003 3E102423 # sw x1, 1000(x0) never runs
E 00000007
H 1

//--- rtl/mem_bus_if.sv
// Core-to-memory bus with one-cycle request and ack strobes; no back-pressure, one request at a time
`timescale 1ns/1ps

interface mem_bus_if;
    import rv_pkg::*;

    // Byte address, word aligned
    logic [XLEN-1:0] addr;
    logic            rd_req;
    logic            wr_req;
    logic [XLEN-1:0] wr_data;
    logic [XLEN-1:0] rd_data;
    logic            ack;

    modport master (
        output addr,
        output rd_req,
        output wr_req,
        output wr_data,
        input  rd_data,
        input  ack
    );

    modport slave (
        input  addr,
        input  rd_req,
        input  wr_req,
        input  wr_data,
        output rd_data,
        output ack
    );

endinterface

//--- rtl/rv_core.sv
// Multi-cycle RV32I subset core (ADDI, LW, SW, branches); any other instruction halts until reset
`timescale 1ns/1ps

module rv_core (
    input  logic                    clk,
    input  logic                    rst,
    mem_bus_if.master               mem,
    output logic                    out_valid,
    output logic [rv_pkg::XLEN-1:0] out_data,
    output logic                    halt
);
    import rv_pkg::*;

    rv_state_e       state;
    logic            boot;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] instr_q;
    logic [XLEN-1:0] regs [32];

    // Fields of the word arriving with the fetch ack
    rv_opcode_e      f_op;
    logic [2:0]      f_funct3;
    logic [4:0]      f_rd;
    logic [4:0]      f_rs1;
    logic [4:0]      f_rs2;
    logic [XLEN-1:0] f_imm_i;
    logic [XLEN-1:0] f_imm_s;
    logic [XLEN-1:0] f_imm_b;

    // Fields of the latched instruction during MEM
    rv_opcode_e      q_op;
    logic [4:0]      q_rd;

    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
    logic [XLEN-1:0] ld_addr;
    logic [XLEN-1:0] st_addr;
    logic            take;

    logic            issue_fetch;
    logic            issue_rd;
    logic            issue_wr;
    logic            out_fire;
    logic            stop;
    logic [XLEN-1:0] next_pc;
    logic [XLEN-1:0] req_addr;
    logic            rf_we;
    logic [4:0]      rf_waddr;
    logic [XLEN-1:0] rf_wdata;

    rv_decode u_dec_fetch (
        .instr  (mem.rd_data),
        .op     (f_op),
        .funct3 (f_funct3),
        .rd     (f_rd),
        .rs1    (f_rs1),
        .rs2    (f_rs2),
        .imm_i  (f_imm_i),
        .imm_s  (f_imm_s),
        .imm_b  (f_imm_b)
    );

    rv_decode u_dec_latched (
        .instr  (instr_q),
        .op     (q_op),
        .funct3 (),
        .rd     (q_rd),
        .rs1    (),
        .rs2    (),
        .imm_i  (),
        .imm_s  (),
        .imm_b  ()
    );

    // x0 is hardwired to zero on read
    assign rs1_val = (f_rs1 == 5'd0) ? '0 : regs[f_rs1];
    assign rs2_val = (f_rs2 == 5'd0) ? '0 : regs[f_rs2];

    assign ld_addr = rs1_val + f_imm_i;
    assign st_addr = rs1_val + f_imm_s;

    always_comb begin
        case (rv_branch_e'(f_funct3))
            BEQ:     take = (rs1_val == rs2_val);
            BNE:     take = (rs1_val != rs2_val);
            BLT:     take = ($signed(rs1_val) < $signed(rs2_val));
            BGE:     take = ($signed(rs1_val) >= $signed(rs2_val));
            BLTU:    take = (rs1_val < rs2_val);
            BGEU:    take = (rs1_val >= rs2_val);
            default: take = 1'b0;
        endcase
    end

    // Per-cycle decisions, registered below
    always_comb begin
        issue_fetch = 1'b0;
        issue_rd    = 1'b0;
        issue_wr    = 1'b0;
        out_fire    = 1'b0;
        stop        = 1'b0;
        next_pc     = pc + 32'd4;
        req_addr    = ld_addr;
        rf_we       = 1'b0;
        rf_waddr    = f_rd;
        rf_wdata    = rs1_val + f_imm_i;
        case (state)
            FETCH: begin
                if (boot) begin
                    issue_fetch = 1'b1;
                    next_pc     = pc;
                end else if (mem.ack) begin
                    case (f_op)
                        OP_IMM: begin
                            if (f_funct3 == F_ADDI) begin
                                rf_we       = 1'b1;
                                issue_fetch = 1'b1;
                            end else begin
                                stop = 1'b1;
                            end
                        end
                        OP_LOAD: begin
                            issue_rd = 1'b1;
                        end
                        OP_STORE: begin
                            if (st_addr == OUT_ADDR) begin
                                out_fire    = 1'b1;
                                issue_fetch = 1'b1;
                            end else if (st_addr == HALT_ADDR) begin
                                stop = 1'b1;
                            end else begin
                                issue_wr = 1'b1;
                                req_addr = st_addr;
                            end
                        end
                        OP_BRANCH: begin
                            issue_fetch = 1'b1;
                            if (take) begin
                                next_pc = pc + f_imm_b;
                            end
                        end
                        default: stop = 1'b1;
                    endcase
                end
            end
            MEM: begin
                if (mem.ack) begin
                    issue_fetch = 1'b1;
                    if (q_op == OP_LOAD) begin
                        rf_we    = 1'b1;
                        rf_waddr = q_rd;
                        rf_wdata = mem.rd_data;
                    end
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= FETCH;
            boot       <= 1'b1;
            pc         <= RESET_PC;
            mem.rd_req <= 1'b0;
            mem.wr_req <= 1'b0;
            out_valid  <= 1'b0;
            halt       <= 1'b0;
        end else begin
            boot       <= 1'b0;
            mem.rd_req <= issue_fetch | issue_rd;
            mem.wr_req <= issue_wr;
            out_valid  <= out_fire;
            if (issue_fetch) begin
                pc <= next_pc;
            end
            if (stop) begin
                state <= HALTED;
                halt  <= 1'b1;
            end else if (issue_rd || issue_wr) begin
                state <= MEM;
            end else if (issue_fetch) begin
                state <= FETCH;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fetch) begin
            mem.addr <= next_pc;
        end else if (issue_rd || issue_wr) begin
            mem.addr <= req_addr;
        end
        if (issue_wr) begin
            mem.wr_data <= rs2_val;
        end
        if (out_fire) begin
            out_data <= rs2_val;
        end
        if (state == FETCH && mem.ack) begin
            instr_q <= mem.rd_data;
        end
        if (rf_we) begin
            regs[rf_waddr] <= rf_wdata;
        end
    end

endmodule

//--- rtl/rv_decode.sv
// Combinational RV32I field decoder; opcodes outside the enum pass through as raw values
`timescale 1ns/1ps

module rv_decode (
    input  logic [rv_pkg::XLEN-1:0] instr,
    output rv_pkg::rv_opcode_e      op,
    output logic [2:0]              funct3,
    output logic [4:0]              rd,
    output logic [4:0]              rs1,
    output logic [4:0]              rs2,
    output logic [rv_pkg::XLEN-1:0] imm_i,
    output logic [rv_pkg::XLEN-1:0] imm_s,
    output logic [rv_pkg::XLEN-1:0] imm_b
);
    import rv_pkg::*;

    logic sign;

    assign sign = instr[31];

    assign op     = rv_opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    // Loads and ADDI
    assign imm_i = {
        {(XLEN - 12){sign}},
        instr[31:20]
    };

    // Stores split the offset around rd
    assign imm_s = {
        {(XLEN - 12){sign}},
        instr[31:25],
        instr[11:7]
    };

    // Branch offset in bytes, always even
    assign imm_b = {
        {(XLEN - 13){sign}},
        instr[31],
        instr[7],
        instr[30:25],
        instr[11:8],
        1'b0
    };

endmodule

//--- rtl/rv_mem.sv
// Word RAM, byte address bits 11:2; one request at a time, load port only while the core is in reset
`timescale 1ns/1ps

module rv_mem (
    input  logic                      clk,
    input  logic                      rst,
    mem_bus_if.slave                  bus,
    input  logic                      load_en,
    input  logic [rv_pkg::MEM_AW-1:0] load_addr,
    input  logic [rv_pkg::XLEN-1:0]   load_data
);
    import rv_pkg::*;

    logic [XLEN-1:0]        ram [MEM_WORDS];
    logic [MEM_AW-1:0]      addr_q;
    logic [MEM_LATENCY-1:0] pipe;
    logic                   req;
    logic [MEM_AW-1:0]      word_addr;

    assign req       = bus.rd_req | bus.wr_req;
    assign word_addr = bus.addr[MEM_AW+1:2];

    // Request strobes age through the pipe, ack leaves its last stage
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pipe    <= '0;
            bus.ack <= 1'b0;
        end else begin
            pipe[0] <= req;
            for (int i = 1; i < MEM_LATENCY; i++) begin
                pipe[i] <= pipe[i-1];
            end
            bus.ack <= pipe[MEM_LATENCY-1];
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            addr_q <= word_addr;
        end
        if (load_en) begin
            ram[load_addr] <= load_data;
        end else if (bus.wr_req) begin
            ram[word_addr] <= bus.wr_data;
        end
        // A write ack returns the freshly written word
        if (pipe[MEM_LATENCY-1]) begin
            bus.rd_data <= ram[addr_q];
        end
    end

endmodule

//--- rtl/rv_pkg.sv
// Shared types and constants for the RV32I subset core; memory size and latency are fixed here
package rv_pkg;

    localparam int XLEN = 32;

    // Word RAM geometry
    localparam int MEM_WORDS = 1024;
    localparam int MEM_AW = $clog2(MEM_WORDS);

    // Cycles from a sampled request to its acknowledge, at least 1
    localparam int MEM_LATENCY = 2;

    // Byte addresses that stores treat specially
    localparam logic [XLEN-1:0] OUT_ADDR = 32'd1000;
    localparam logic [XLEN-1:0] HALT_ADDR = 32'd1004;

    localparam logic [XLEN-1:0] RESET_PC = '0;

    typedef enum logic [6:0] {
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011
    } rv_opcode_e;

    typedef enum logic [2:0] {
        BEQ  = 3'b000,
        BNE  = 3'b001,
        BLT  = 3'b100,
        BGE  = 3'b101,
        BLTU = 3'b110,
        BGEU = 3'b111
    } rv_branch_e;

    // Only ADDI is implemented among the OP-IMM group
    typedef enum logic [2:0] {
        F_ADDI = 3'b000
    } rv_imm_funct_e;

    typedef enum logic [1:0] {
        FETCH,
        MEM,
        HALTED
    } rv_state_e;

endpackage

//--- rtl/rv_soc.sv
// Core plus word RAM; program is loaded through load_en/load_addr/load_data while rst is high
`timescale 1ns/1ps

module rv_soc (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   load_en,
    input  logic [$clog2(rv_pkg::MEM_WORDS)-1:0]   load_addr,
    input  logic [rv_pkg::XLEN-1:0]                load_data,
    output logic                                   out_valid,
    output logic [rv_pkg::XLEN-1:0]                out_data,
    output logic                                   halt
);

    mem_bus_if bus ();

    rv_core u_core (
        .clk       (clk),
        .rst       (rst),
        .mem       (bus.master),
        .out_valid (out_valid),
        .out_data  (out_data),
        .halt      (halt)
    );

    rv_mem u_mem (
        .clk       (clk),
        .rst       (rst),
        .bus       (bus.slave),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data)
    );

endmodule

//--- rv_soc.f
rtl/rv_pkg.sv
rtl/mem_bus_if.sv
rtl/rv_decode.sv
rtl/rv_core.sv
rtl/rv_mem.sv
rtl/rv_soc.sv
bench/rv_soc_tb.sv
